// ==== hdl/bus_link.sv ====
`default_nettype none

// Registered bus link: transmit bookend, register chain, receive bookend
module bus_link import bus_link_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,

    // Source port
    input  wire logic  in_valid,
    input  wire data_t in_data,
    output logic       in_ready,

    // Sink port
    output logic       out_valid,
    output data_t      out_data,
    input  wire logic  out_ready
);

    logic  link_valid;
    data_t link_data;
    logic  link_reset;
    logic  tx_ready;

    logic  rx_valid;
    data_t rx_data;
    logic  rx_reset;
    logic  rx_ready;

    bus_pipe_tx i_bus_pipe_tx (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .tx_ready   (tx_ready),
        .link_valid (link_valid),
        .link_data  (link_data),
        .link_reset (link_reset)
    );

    bus_reg_multi i_bus_reg_multi (
        .clk        (clk),
        .link_reset (link_reset),
        .link_valid (link_valid),
        .link_data  (link_data),
        .tx_ready   (tx_ready),
        .rx_reset   (rx_reset),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_ready   (rx_ready)
    );

    bus_pipe_rx i_bus_pipe_rx (
        .clk       (clk),
        .rx_reset  (rx_reset),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule : bus_link

`default_nettype wire

// ==== hdl/bus_link_pkg.sv ====
`default_nettype none

package bus_link_pkg;

    // Width of one bus word
    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // Register stages in each direction of the link
    localparam int LINK_STAGES = 3;

    // Words that can still land after the receiver drops ready.
    // This covers the ready delay, the transmit register and the forward delay plus one.
    localparam int RX_SLACK = 2 * LINK_STAGES + 2;

    // Receive buffer entries, a power of two and at least twice the slack
    localparam int RX_DEPTH = 16;

    localparam int RX_PTR_WIDTH = $clog2(RX_DEPTH);

    // Buffer index
    typedef logic [RX_PTR_WIDTH-1:0] rx_ptr_t;

    // Fill level, one bit wider so that a full buffer is representable
    typedef logic [RX_PTR_WIDTH:0] rx_count_t;

endpackage : bus_link_pkg

`default_nettype wire

// ==== hdl/bus_pipe_rx.sv ====
`default_nettype none

// Receive bookend. Absorbs every word in flight, then presents a
// standard valid/ready port from a show-ahead buffer
module bus_pipe_rx import bus_link_pkg::*; (
    input  wire logic  clk,

    // Link side, every rx_valid word is taken
    input  wire logic  rx_reset,
    input  wire logic  rx_valid,
    input  wire data_t rx_data,
    output logic       rx_ready,

    // Downstream valid/ready port
    output logic       out_valid,
    output data_t      out_data,
    input  wire logic  out_ready
);

    data_t mem [RX_DEPTH];

    rx_ptr_t   wr_ptr;
    rx_ptr_t   rd_ptr;
    rx_count_t count;
    rx_count_t count_next;

    logic push;
    logic pop;
    logic full;

    assign push = rx_valid;
    assign pop  = out_valid && out_ready;
    assign full = (count == rx_count_t'(RX_DEPTH));

    // Head of the buffer is always on the output
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
        end
    end

    // Ready based on the next fill level, so it drops on the edge
    // where the free space reaches the slack
    always_ff @(posedge clk) begin
        if (rx_reset) begin
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= (rx_count_t'(RX_DEPTH) - count_next) > rx_count_t'(RX_SLACK);
        end
    end

    // A write into a full buffer means the slack sizing upstream is wrong
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rx_reset)
        push |-> !full
    ) else $error("receive buffer overflow");

    // Held word stays put under back-pressure
    a_out_stable : assert property (
        @(posedge clk) disable iff (rx_reset)
        out_valid && !out_ready |=> $stable(out_data)
    ) else $error("out_data changed while stalled");

endmodule : bus_pipe_rx

`default_nettype wire

// ==== hdl/bus_pipe_tx.sv ====
`default_nettype none

module bus_pipe_tx import bus_link_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,

    // Upstream valid/ready port
    input  wire logic  in_valid,
    input  wire data_t in_data,
    output logic       in_ready,

    // Link side, no handshake applied here
    input  wire logic  tx_ready,
    output logic       link_valid,
    output data_t      link_data,
    output logic       link_reset
);

    logic accept;

    // Only delayed ready may open the gate
    assign accept   = in_valid && tx_ready;
    assign in_ready = tx_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            link_valid <= 1'b0;
        end else begin
            link_valid <= accept;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (accept) begin
            link_data <= in_data;
        end
    end

    // Travelling reset, registered so it lines up with the link word
    always_ff @(posedge clk) begin
        link_reset <= reset;
    end

    // A refused word stays on the source port until it is taken
    a_in_hold : assert property (
        @(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_data)
    ) else $error("in_valid or in_data changed before the transfer");

endmodule : bus_pipe_tx

`default_nettype wire

// ==== hdl/bus_reg_multi.sv ====
`default_nettype none

// Multi-stage register chain for a valid/data/ready link.
// Forward path carries reset, valid and data, reverse path carries ready.
// Delaying ready breaks the handshake, so both ends need bookends.
module bus_reg_multi import bus_link_pkg::*; #(
    parameter int STAGES = LINK_STAGES
) (
    input  wire logic  clk,

    // From the transmit side
    input  wire logic  link_reset,
    input  wire logic  link_valid,
    input  wire data_t link_data,
    output logic       tx_ready,

    // To the receive side
    output logic       rx_reset,
    output logic       rx_valid,
    output data_t      rx_data,
    input  wire logic  rx_ready
);

    // Elaboration check
    if (STAGES < 1) begin : g_stages_check
        $error("bus_reg_multi: STAGES must be greater than zero");
    end

    (* shreg_extract = "no" *) logic  reset_p [STAGES];
    (* shreg_extract = "no" *) logic  valid_p [STAGES];
    (* shreg_extract = "no" *) data_t data_p  [STAGES];
    (* shreg_extract = "no" *) logic  ready_p [STAGES];

    // Reset chain sets at once and releases STAGES cycles later
    always_ff @(posedge clk) begin
        if (link_reset) begin
            for (int i = 0; i < STAGES; i++) begin
                reset_p[i] <= 1'b1;
            end
        end else begin
            reset_p[0] <= 1'b0;
            for (int i = 1; i < STAGES; i++) begin
                reset_p[i] <= reset_p[i-1];
            end
        end
    end

    // Valid chain, flushed by the travelling reset
    always_ff @(posedge clk) begin
        if (link_reset) begin
            for (int i = 0; i < STAGES; i++) begin
                valid_p[i] <= 1'b0;
            end
        end else begin
            valid_p[0] <= link_valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_p[i] <= valid_p[i-1];
            end
        end
    end

    // Data chain
    always_ff @(posedge clk) begin
        data_p[0] <= link_data;
        for (int i = 1; i < STAGES; i++) begin
            data_p[i] <= data_p[i-1];
        end
    end

    // Ready chain held low until the receiver leaves reset
    always_ff @(posedge clk) begin
        if (rx_reset) begin
            for (int i = 0; i < STAGES; i++) begin
                ready_p[i] <= 1'b0;
            end
        end else begin
            ready_p[0] <= rx_ready;
            for (int i = 1; i < STAGES; i++) begin
                ready_p[i] <= ready_p[i-1];
            end
        end
    end

    assign rx_reset = reset_p[STAGES-1];
    assign rx_valid = valid_p[STAGES-1];
    assign rx_data  = data_p[STAGES-1];
    assign tx_ready = ready_p[STAGES-1];

endmodule : bus_reg_multi

`default_nettype wire

// ==== tb/bus_link_tb.sv ====
`default_nettype none

module bus_link_tb import bus_link_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    localparam int LATENCY = LINK_STAGES + 2;
    // Rough length of each test in cycles, in run order
    localparam int TEST_CYCLES = 20 + 20 + 80 + 60 + 460 + 60;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 200;

    logic  clk;
    logic  reset;
    logic  in_valid;
    data_t in_data;
    logic  in_ready;
    logic  out_valid;
    data_t out_data;
    logic  out_ready;

    // Reference model and transfer history
    data_t ref_q[$];
    int    acc_cycles[$];
    int    out_cycles[$];
    data_t expected_word;
    int    cycle = 0;
    int    errors = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    logic  checking = 1'b0;

    bus_link i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Scoreboard sees pre-edge values of inputs and outputs
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!reset && in_valid && in_ready) begin
            ref_q.push_back(in_data);
            acc_cycles.push_back(cycle);
        end
        if (checking && out_valid && out_ready) begin
            out_cycles.push_back(cycle);
            assert (ref_q.size() > 0) else begin
                $display("Output word %h at %0t has no matching input", out_data, $time);
                errors++;
            end
            if (ref_q.size() > 0) begin
                expected_word = ref_q.pop_front();
                assert (out_data === expected_word) else begin
                    $display("CHECK FAILED at %0t: out_data expected %h, actual %h",
                             $time, expected_word, out_data);
                    errors++;
                end
            end
        end
    end

    task automatic check_int(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED at %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic clear_history;
        acc_cycles.delete();
        out_cycles.delete();
    endtask

    // Word transfers on the posedge after the negedge where in_ready is seen high
    task automatic send_word(input data_t word);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b1;
        in_data  = word;
        while (in_ready !== 1'b1 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        assert (waited < 100) else begin
            $display("in_ready stayed low for 100 cycles while sending at %0t", $time);
            errors++;
        end
    endtask

    task automatic stop_sending;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (ref_q.size() > 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (ref_q.size() == 0) else begin
            $display("%0d words never came out within %0d cycles", ref_q.size(), limit);
            errors++;
        end
        // Give any extra word time to show up
        repeat (LATENCY) @(negedge clk);
    endtask

    task automatic reset_state;
        int e0;
        int waited;
        e0 = errors;
        repeat (5) @(negedge clk);
        assert (in_ready === 1'b0 && out_valid === 1'b0) else begin
            $display("CHECK FAILED at %0t: in_ready/out_valid expected 0/0, actual %b/%b",
                     $time, in_ready, out_valid);
            errors++;
        end
        reset    = 1'b0;
        checking = 1'b1;
        waited   = 0;
        while (in_ready !== 1'b1 && waited <= 4 * LINK_STAGES) begin
            @(negedge clk);
            waited++;
            check_int("out_valid after reset", 0, int'(out_valid === 1'b1));
        end
        assert (waited <= 4 * LINK_STAGES) else begin
            $display("in_ready did not rise within %0d cycles of reset", 4 * LINK_STAGES);
            errors++;
        end
        report_test("reset_state", e0);
    endtask

    task automatic fixed_latency;
        int e0;
        e0 = errors;
        clear_history();
        out_ready = 1'b1;
        send_word($urandom);
        stop_sending();
        wait_drain(100);
        check_int("delivered words", 1, out_cycles.size());
        if (out_cycles.size() == 1 && acc_cycles.size() == 1) begin
            check_int("out_valid latency", LATENCY, out_cycles[0] - acc_cycles[0]);
        end
        report_test("fixed_latency", e0);
    endtask

    task automatic streaming;
        int e0;
        int i;
        e0 = errors;
        clear_history();
        out_ready = 1'b1;
        for (i = 0; i < 64; i++) begin
            send_word($urandom);
        end
        stop_sending();
        wait_drain(200);
        check_int("accepted words", 64, acc_cycles.size());
        check_int("delivered words", 64, out_cycles.size());
        // Back-to-back on both sides means each span is exactly 63 cycles
        if (acc_cycles.size() == 64 && out_cycles.size() == 64) begin
            check_int("accept span", 63, acc_cycles[63] - acc_cycles[0]);
            check_int("output span", 63, out_cycles[63] - out_cycles[0]);
        end
        report_test("streaming", e0);
    endtask

    task automatic back_pressure;
        int   e0;
        int   guard;
        int   accepted;
        logic offering;
        e0 = errors;
        clear_history();
        out_ready = 1'b0;
        offering  = 1'b1;
        guard     = 0;
        // A new word goes out only while in_ready is high, so none is withdrawn
        while (offering && guard < 4 * RX_DEPTH) begin
            @(negedge clk);
            guard++;
            offering = (in_ready === 1'b1);
            in_valid = offering;
            in_data  = $urandom;
        end
        assert (!offering) else begin
            $display("in_ready never fell with out_ready held low");
            errors++;
        end
        repeat (2 * LINK_STAGES + 4) @(negedge clk);
        accepted = acc_cycles.size();
        assert (accepted > 0 && accepted <= RX_DEPTH) else begin
            $display("CHECK FAILED at %0t: accepted words expected 1 to %0d, actual %0d",
                     $time, RX_DEPTH, accepted);
            errors++;
        end
        // The oldest buffered word waits on the output
        check_int("out_valid while stalled", 1, int'(out_valid === 1'b1));
        out_ready = 1'b1;
        wait_drain(100);
        check_int("delivered words", accepted, out_cycles.size());
        report_test("back_pressure", e0);
    endtask

    task automatic random_traffic;
        int   e0;
        int   c;
        int   guard;
        logic ready_seen;
        e0 = errors;
        clear_history();
        ready_seen = 1'b0;
        for (c = 0; c < 400; c++) begin
            @(negedge clk);
            // Hold a pending word until it transfers
            if (!in_valid || ready_seen) begin
                in_valid = ($urandom % 2) == 1;
                in_data  = $urandom;
            end
            out_ready  = ($urandom % 2) == 1;
            ready_seen = (in_ready === 1'b1);
        end
        @(negedge clk);
        out_ready = 1'b1;
        guard     = 0;
        while (in_valid && !ready_seen && guard < 100) begin
            ready_seen = (in_ready === 1'b1);
            @(negedge clk);
            guard++;
        end
        in_valid = 1'b0;
        wait_drain(200);
        check_int("delivered words", acc_cycles.size(), out_cycles.size());
        report_test("random_traffic", e0);
    endtask

    task automatic reset_mid_stream;
        int e0;
        int i;
        int waited;
        e0 = errors;
        clear_history();
        // Stalled sink keeps words in the buffer and the chain when reset hits
        out_ready = 1'b0;
        for (i = 0; i < 12; i++) begin
            send_word($urandom);
        end
        @(negedge clk);
        reset    = 1'b1;
        in_valid = 1'b0;
        checking = 1'b0;
        repeat (5) @(negedge clk);
        ref_q.delete();
        clear_history();
        reset     = 1'b0;
        out_ready = 1'b1;
        checking  = 1'b1;
        waited    = 0;
        while (in_ready !== 1'b1 && waited <= 4 * LINK_STAGES) begin
            assert (out_valid === 1'b0) else begin
                $display("CHECK FAILED at %0t: out_valid expected 0, actual %b",
                         $time, out_valid);
                errors++;
            end
            @(negedge clk);
            waited++;
        end
        assert (waited <= 4 * LINK_STAGES) else begin
            $display("in_ready did not come back after reset during traffic");
            errors++;
        end
        for (i = 0; i < 16; i++) begin
            send_word($urandom);
        end
        stop_sending();
        wait_drain(200);
        check_int("accepted words", 16, acc_cycles.size());
        check_int("delivered words", 16, out_cycles.size());
        report_test("reset_mid_stream", e0);
    endtask

    initial begin
        void'($urandom(32'h93d8879b));
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        reset_state();
        fixed_latency();
        streaming();
        back_pressure();
        random_traffic();
        reset_mid_stream();
        $display("Summary: passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule : bus_link_tb

`default_nettype wire

// ==== verilog.f ====
hdl/bus_link_pkg.sv
hdl/bus_pipe_tx.sv
hdl/bus_reg_multi.sv
hdl/bus_pipe_rx.sv
hdl/bus_link.sv
tb/bus_link_tb.sv
